/* src/vmicro16_pkg.sv */
// Vmicro16 memory subsystem
// Shared types and address map
package vmicro16_pkg;

    // Words per memory block
    localparam int MEM_DEPTH = 64;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;
    typedef logic [2:0] sreg_sel_t;
    typedef logic [7:0] gpio_t;

    // Tightly integrated scratch memory
    localparam addr_t TIM0_START = 16'h0000;
    localparam addr_t TIM0_END   = 16'h003F;

    // Read-only special registers
    localparam addr_t SREG_START = 16'h0080;
    localparam addr_t SREG_END   = 16'h0087;

    // APB peripherals
    localparam addr_t GPIO_ADDR  = 16'h0090;
    localparam addr_t BRAM_START = 16'h00C0;
    localparam addr_t BRAM_END   = 16'h00FF;

    // Value of special register 0
    localparam word_t CORE_ID = 16'h0003;

    // APB master sequencing in the memory unit
    typedef enum {
        IDLE,
        SETUP,
        ACCESS,
        DONE
    } mmu_state_e;

endpackage

/* src/apb_if.sv */
// APB bus
`timescale 1ns/1ns

interface apb_if;
    vmicro16_pkg::addr_t paddr;
    logic                pwrite;
    logic                psel;
    logic                penable;
    vmicro16_pkg::word_t pwdata;
    vmicro16_pkg::word_t prdata;
    logic                pready;

    // Memory unit side
    modport master (
        output paddr,
        output pwrite,
        output psel,
        output penable,
        output pwdata,
        input  prdata,
        input  pready
    );

    // Peripheral bus side
    modport slave (
        input  paddr,
        input  pwrite,
        input  psel,
        input  penable,
        input  pwdata,
        output prdata,
        output pready
    );
endinterface

/* src/vmicro16_bram.sv */
// Single-port block RAM
`timescale 1ns/1ns

module vmicro16_bram #(
    parameter int DEPTH = vmicro16_pkg::MEM_DEPTH
) (
    input  logic                    clk,
    input  vmicro16_pkg::mem_addr_t addr,
    input  vmicro16_pkg::word_t     wdata,
    input  logic                    we,
    output vmicro16_pkg::word_t     rdata
);
    vmicro16_pkg::word_t mem [0:DEPTH-1];

    // Write cycles leave the read port holding its last word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end
endmodule

/* src/vmicro16_gpio_apb.sv */
// APB GPIO output port
`timescale 1ns/1ns

module vmicro16_gpio_apb (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  vmicro16_pkg::word_t pwdata,
    output vmicro16_pkg::word_t prdata,
    output vmicro16_pkg::gpio_t gpio
);
    logic access;

    assign access = psel && penable;

    // Port register loaded from the low byte
    always_ff @(posedge clk) begin
        if (reset) begin
            gpio <= '0;
        end else if (access && pwrite) begin
            gpio <= pwdata[7:0];
        end
    end

    assign prdata = access ? vmicro16_pkg::word_t'(gpio) : '0;
endmodule

/* src/vmicro16_mmu.sv */
// Core memory unit
// Scratch memory, special registers and APB master
`timescale 1ns/1ns

module vmicro16_mmu (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                we,
    input  vmicro16_pkg::addr_t addr,
    input  vmicro16_pkg::word_t wdata,
    output logic                busy,
    output vmicro16_pkg::word_t rdata,
    apb_if.master               apb
);
    vmicro16_pkg::mmu_state_e state;

    logic                    tim0_hit;
    logic                    sreg_hit;
    logic                    apb_hit;
    logic                    apb_launch;
    logic                    tim0_we;
    vmicro16_pkg::mem_addr_t tim0_addr;
    vmicro16_pkg::word_t     tim0_rdata;
    vmicro16_pkg::sreg_sel_t sreg_idx;
    vmicro16_pkg::word_t     sreg_val;
    vmicro16_pkg::word_t     per_data;
    logic                    tim0_sel_q;
    logic                    sreg_sel_q;

    // Anything outside TIM0 and the special registers decodes to APB
    assign tim0_hit = (addr >= vmicro16_pkg::TIM0_START) && (addr <= vmicro16_pkg::TIM0_END);
    assign sreg_hit = (addr >= vmicro16_pkg::SREG_START) && (addr <= vmicro16_pkg::SREG_END);
    assign apb_hit  = !tim0_hit && !sreg_hit;

    assign tim0_addr = vmicro16_pkg::mem_addr_t'(addr - vmicro16_pkg::TIM0_START);
    assign tim0_we   = req && we && tim0_hit;
    assign sreg_idx  = vmicro16_pkg::sreg_sel_t'(addr - vmicro16_pkg::SREG_START);

    // A new transfer may also start in the DONE cycle
    assign apb_launch = req && apb_hit
                     && ((state == vmicro16_pkg::IDLE) || (state == vmicro16_pkg::DONE));

    assign busy = req || (state == vmicro16_pkg::SETUP) || (state == vmicro16_pkg::ACCESS);

    // Per-core scratch memory
    vmicro16_bram u_tim0 (
        .clk   (clk),
        .addr  (tim0_addr),
        .wdata (wdata),
        .we    (tim0_we),
        .rdata (tim0_rdata)
    );

    // Only register 0 holds a value and writes are dropped
    always_ff @(posedge clk) begin
        if (req && sreg_hit) begin
            sreg_val <= (sreg_idx == '0) ? vmicro16_pkg::CORE_ID : '0;
        end
    end

    // Remember which target answers the current request
    always_ff @(posedge clk) begin
        if (reset) begin
            tim0_sel_q <= 1'b0;
            sreg_sel_q <= 1'b0;
        end else if (req) begin
            tim0_sel_q <= tim0_hit;
            sreg_sel_q <= sreg_hit;
        end
    end

    // APB master sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= vmicro16_pkg::IDLE;
            apb.psel    <= 1'b0;
            apb.penable <= 1'b0;
        end else begin
            case (state)
                vmicro16_pkg::IDLE,
                vmicro16_pkg::DONE: begin
                    if (apb_launch) begin
                        apb.psel <= 1'b1;
                        state    <= vmicro16_pkg::SETUP;
                    end else begin
                        state <= vmicro16_pkg::IDLE;
                    end
                end
                vmicro16_pkg::SETUP: begin
                    apb.penable <= 1'b1;
                    state       <= vmicro16_pkg::ACCESS;
                end
                vmicro16_pkg::ACCESS: begin
                    // Wait states keep the bus in access
                    if (apb.pready) begin
                        apb.psel    <= 1'b0;
                        apb.penable <= 1'b0;
                        state       <= vmicro16_pkg::DONE;
                    end
                end
                default: begin
                    state <= vmicro16_pkg::IDLE;
                end
            endcase
        end
    end

    // Address and data stay put until the next transfer
    always_ff @(posedge clk) begin
        if (apb_launch) begin
            apb.paddr  <= addr;
            apb.pwdata <= wdata;
            apb.pwrite <= we;
        end
        if ((state == vmicro16_pkg::ACCESS) && apb.pready) begin
            per_data <= apb.prdata;
        end
    end

    // Read data from whichever target the last request hit
    always_comb begin
        if (tim0_sel_q) begin
            rdata = tim0_rdata;
        end else if (sreg_sel_q) begin
            rdata = sreg_val;
        end else begin
            rdata = per_data;
        end
    end
endmodule

/* src/vmicro16_periph_bus.sv */
// APB peripheral bus
// GPIO port and shared block RAM
`timescale 1ns/1ns

module vmicro16_periph_bus (
    input  logic                clk,
    input  logic                reset,
    apb_if.slave                apb,
    output vmicro16_pkg::gpio_t gpio
);
    logic                    access;
    logic                    gpio_sel;
    logic                    bram_sel;
    logic                    bram_we;
    vmicro16_pkg::mem_addr_t bram_addr;
    vmicro16_pkg::word_t     bram_rdata;
    vmicro16_pkg::word_t     gpio_rdata;

    assign access = apb.psel && apb.penable;

    // Peripheral select from paddr
    assign gpio_sel = (apb.paddr == vmicro16_pkg::GPIO_ADDR);
    assign bram_sel = (apb.paddr >= vmicro16_pkg::BRAM_START)
                   && (apb.paddr <= vmicro16_pkg::BRAM_END);

    // Address is valid from setup, so the read word is ready in access
    assign bram_addr = vmicro16_pkg::mem_addr_t'(apb.paddr - vmicro16_pkg::BRAM_START);
    assign bram_we   = bram_sel && access && apb.pwrite;

    vmicro16_gpio_apb u_gpio0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (apb.psel && gpio_sel),
        .penable (apb.penable),
        .pwrite  (apb.pwrite),
        .pwdata  (apb.pwdata),
        .prdata  (gpio_rdata),
        .gpio    (gpio)
    );

    // Block RAM shared with other cores on the bus
    vmicro16_bram u_bram0 (
        .clk   (clk),
        .addr  (bram_addr),
        .wdata (apb.pwdata),
        .we    (bram_we),
        .rdata (bram_rdata)
    );

    // All peripherals here are zero-wait
    assign apb.pready = access;

    // Zero outside access and for unmapped addresses
    always_comb begin
        if (!access) begin
            apb.prdata = '0;
        end else if (gpio_sel) begin
            apb.prdata = gpio_rdata;
        end else if (bram_sel) begin
            apb.prdata = bram_rdata;
        end else begin
            apb.prdata = '0;
        end
    end
endmodule

/* src/vmicro16_mem_sys.sv */
// Vmicro16 memory subsystem top
`timescale 1ns/1ns

module vmicro16_mem_sys (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  logic                we,
    input  vmicro16_pkg::addr_t addr,
    input  vmicro16_pkg::word_t wdata,
    output logic                busy,
    output vmicro16_pkg::word_t rdata,
    output vmicro16_pkg::gpio_t gpio
);
    // Core to peripheral bus
    apb_if u_apb ();

    vmicro16_mmu u_mmu (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .rdata (rdata),
        .apb   (u_apb.master)
    );

    vmicro16_periph_bus u_periph (
        .clk   (clk),
        .reset (reset),
        .apb   (u_apb.slave),
        .gpio  (gpio)
    );
endmodule

/* bench/tb_mem_sys.sv */
// Vmicro16 memory subsystem testbench
`timescale 1ns/1ns

module tb_mem_sys;
    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int SCRATCH_WORDS = 32;
    localparam int BRAM_WORDS    = 32;
    localparam int ISO_OFFSETS   = 8;

    // Accesses issued by all tests together
    localparam int NUM_ACCESSES = 2 * SCRATCH_WORDS + 10 + 4 + 2 * BRAM_WORDS
                                + 5 * ISO_OFFSETS + 14;
    localparam int TIMEOUT_NS   = (NUM_ACCESSES * 10 + RESET_CYCLES) * CLK_PERIOD;

    logic                clk;
    logic                reset;
    logic                req;
    logic                we;
    vmicro16_pkg::addr_t addr;
    vmicro16_pkg::word_t wdata;
    logic                busy;
    vmicro16_pkg::word_t rdata;
    vmicro16_pkg::gpio_t gpio;

    // Shadow state of the memory map
    vmicro16_pkg::word_t tim0_model [0:vmicro16_pkg::MEM_DEPTH-1];
    vmicro16_pkg::word_t bram_model [0:vmicro16_pkg::MEM_DEPTH-1];
    vmicro16_pkg::gpio_t gpio_model;

    logic [31:0] rng_state = 32'hf97c_fb0a;

    // Results waiting for the compare process
    string               name_q [$];
    vmicro16_pkg::word_t exp_q [$];
    vmicro16_pkg::word_t act_q [$];
    int                  pending = 0;

    int error_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    vmicro16_mem_sys u_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .rdata (rdata),
        .gpio  (gpio)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected read value from the address map and the shadow state
    function automatic vmicro16_pkg::word_t expected_read(input vmicro16_pkg::addr_t a);
        if (a <= vmicro16_pkg::TIM0_END) begin
            return tim0_model[a - vmicro16_pkg::TIM0_START];
        end
        if ((a >= vmicro16_pkg::SREG_START) && (a <= vmicro16_pkg::SREG_END)) begin
            return (a == vmicro16_pkg::SREG_START) ? vmicro16_pkg::CORE_ID : 16'h0000;
        end
        if (a == vmicro16_pkg::GPIO_ADDR) begin
            return {8'h00, gpio_model};
        end
        if ((a >= vmicro16_pkg::BRAM_START) && (a <= vmicro16_pkg::BRAM_END)) begin
            return bram_model[a - vmicro16_pkg::BRAM_START];
        end
        return 16'h0000;
    endfunction

    // Special registers and holes in the map keep nothing
    task automatic model_write(input vmicro16_pkg::addr_t a, input vmicro16_pkg::word_t d);
        if (a <= vmicro16_pkg::TIM0_END) begin
            tim0_model[a - vmicro16_pkg::TIM0_START] = d;
        end else if (a == vmicro16_pkg::GPIO_ADDR) begin
            gpio_model = d[7:0];
        end else if ((a >= vmicro16_pkg::BRAM_START) && (a <= vmicro16_pkg::BRAM_END)) begin
            bram_model[a - vmicro16_pkg::BRAM_START] = d;
        end
    endtask

    task automatic check_value(input string name, input vmicro16_pkg::word_t expected,
                               input vmicro16_pkg::word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic queue_result(input string name, input vmicro16_pkg::word_t expected,
                                input vmicro16_pkg::word_t actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        pending++;
    endtask

    initial begin : compare_results
        string               n;
        vmicro16_pkg::word_t e;
        vmicro16_pkg::word_t a;
        forever begin
            wait (pending != 0);
            n = name_q.pop_front();
            e = exp_q.pop_front();
            a = act_q.pop_front();
            check_value(n, e, a);
            pending--;
        end
    end

    // Issue one request and hold it until busy falls
    task automatic do_access(input logic is_write, input vmicro16_pkg::addr_t a,
                             input vmicro16_pkg::word_t d, output vmicro16_pkg::word_t rd);
        @(posedge clk);
        req   <= 1'b1;
        we    <= is_write;
        addr  <= a;
        wdata <= d;
        @(negedge clk);
        if (!busy) begin
            $display("Request to address %h did not raise busy", a);
            error_count++;
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        rd = rdata;
    endtask

    task automatic write_word(input vmicro16_pkg::addr_t a, input vmicro16_pkg::word_t d);
        vmicro16_pkg::word_t unused;
        do_access(1'b1, a, d, unused);
        model_write(a, d);
    endtask

    task automatic read_check(input string name, input vmicro16_pkg::addr_t a);
        vmicro16_pkg::word_t rd;
        do_access(1'b0, a, 16'h0000, rd);
        queue_result($sformatf("%s @%h", name, a), expected_read(a), rd);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        wait (pending == 0);
        if (error_count == errs_before) begin
            $display("PASS  %s", name);
            tests_passed++;
        end else begin
            $display("FAIL  %s", name);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = error_count;
        @(negedge clk);
        queue_result("reset busy", 16'h0000, {15'h0000, busy});
        queue_result("reset gpio", 16'h0000, {8'h00, gpio});
        finish_test("reset state", errs);
    endtask

    task automatic test_scratch();
        int                  errs;
        logic [31:0]         r;
        vmicro16_pkg::addr_t addrs [0:SCRATCH_WORDS-1];
        errs = error_count;
        for (int i = 0; i < SCRATCH_WORDS; i++) begin
            r = next_random();
            addrs[i] = vmicro16_pkg::TIM0_START + r[5:0];
            write_word(addrs[i], r[31:16]);
        end
        for (int i = 0; i < SCRATCH_WORDS; i++) begin
            read_check("scratch", addrs[i]);
        end
        finish_test("scratch memory", errs);
    endtask

    task automatic test_sreg();
        int          errs;
        logic [31:0] r;
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            read_check("special register", vmicro16_pkg::SREG_START + i);
        end
        // Read-only, so the core id survives a write
        r = next_random();
        write_word(vmicro16_pkg::SREG_START, r[15:0]);
        read_check("special register after write", vmicro16_pkg::SREG_START);
        finish_test("special registers", errs);
    endtask

    task automatic test_gpio();
        int          errs;
        logic [31:0] r;
        errs = error_count;
        repeat (2) begin
            r = next_random();
            write_word(vmicro16_pkg::GPIO_ADDR, r[15:0]);
            queue_result("gpio port", {8'h00, gpio_model}, {8'h00, gpio});
            read_check("gpio read", vmicro16_pkg::GPIO_ADDR);
        end
        finish_test("gpio", errs);
    endtask

    task automatic test_bram();
        int                  errs;
        logic [31:0]         r;
        vmicro16_pkg::addr_t addrs [0:BRAM_WORDS-1];
        errs = error_count;
        for (int i = 0; i < BRAM_WORDS; i++) begin
            r = next_random();
            addrs[i] = vmicro16_pkg::BRAM_START + r[5:0];
            write_word(addrs[i], r[31:16]);
        end
        for (int i = 0; i < BRAM_WORDS; i++) begin
            read_check("block ram", addrs[i]);
        end
        finish_test("block ram over apb", errs);
    endtask

    // Same offsets in both memories must not alias
    task automatic test_isolation();
        int          errs;
        logic [31:0] r;
        logic [5:0]  off;
        errs = error_count;
        for (int i = 0; i < ISO_OFFSETS; i++) begin
            r   = next_random();
            off = r[5:0];
            write_word(vmicro16_pkg::BRAM_START + off, r[31:16]);
            r = next_random();
            write_word(vmicro16_pkg::TIM0_START + off, r[15:0]);
            read_check("isolation block ram", vmicro16_pkg::BRAM_START + off);
            r = next_random();
            write_word(vmicro16_pkg::BRAM_START + off, r[15:0]);
            read_check("isolation scratch", vmicro16_pkg::TIM0_START + off);
        end
        finish_test("memory isolation", errs);
    endtask

    task automatic test_unmapped();
        int                  errs;
        logic [31:0]         r;
        vmicro16_pkg::addr_t holes [0:2];
        errs = error_count;
        holes[0] = 16'h0040;
        holes[1] = 16'h00A0;
        holes[2] = 16'h0100;
        for (int i = 0; i < 3; i++) begin
            read_check("unmapped", holes[i]);
        end
        write_word(vmicro16_pkg::TIM0_START, 16'h1234);
        write_word(vmicro16_pkg::BRAM_START, 16'hABCD);
        for (int i = 0; i < 3; i++) begin
            r = next_random();
            write_word(holes[i], r[15:0]);
        end
        for (int i = 0; i < 3; i++) begin
            read_check("unmapped after write", holes[i]);
        end
        read_check("scratch after hole write", vmicro16_pkg::TIM0_START);
        read_check("block ram after hole write", vmicro16_pkg::BRAM_START);
        read_check("gpio after hole write", vmicro16_pkg::GPIO_ADDR);
        finish_test("unmapped addresses", errs);
    endtask

    initial begin
        reset      = 1'b1;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        gpio_model = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset();
        test_scratch();
        test_sreg();
        test_gpio();
        test_bram();
        test_isolation();
        test_unmapped();

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, error_count);
        if ((tests_failed == 0) && (error_count == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns before all tests finished", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end
endmodule

/* tb.f */
src/vmicro16_pkg.sv
src/apb_if.sv
src/vmicro16_bram.sv
src/vmicro16_gpio_apb.sv
src/vmicro16_mmu.sv
src/vmicro16_periph_bus.sv
src/vmicro16_mem_sys.sv
bench/tb_mem_sys.sv
